// File: design/pixel_cfg.svh
`ifndef PIXEL_CFG_SVH
`define PIXEL_CFG_SVH

// ========================================
// Frame buffer geometry
// ========================================

// Words held by the dual-port macro
`define PIX_WORDS 1024
// Word address width, log2 of PIX_WORDS
`define PIX_ADDR_W 10

// One pixel lane
`define PIX_W 16
// Pixel lanes packed into one memory word
`define PIX_LANES 3

`endif

// File: design/pixel_pkg.sv
`include "pixel_cfg.svh"

package pixel_pkg;

  // ========================================
  // Datapath types
  // ========================================

  // One pixel as it arrives on the stream
  typedef logic [`PIX_W-1:0] pix_t;

  // Full memory word, lane 0 in the low bits
  typedef logic [`PIX_LANES*`PIX_W-1:0] word_t;

  // Word address into the frame buffer
  typedef logic [`PIX_ADDR_W-1:0] addr_t;

  // Lane write enables, active low
  // Bit i covers word bits 16i+15 down to 16i
  typedef logic [`PIX_LANES-1:0] lane_we_t;

  // Completed words, one bit wider so a full buffer fits
  typedef logic [`PIX_ADDR_W:0] count_t;

endpackage

// File: design/pix_mem_if.sv
`timescale 1ns/10ps

interface pix_mem_if
  import pixel_pkg::*;
();

  // Port A, write only
  addr_t    wr_addr;
  lane_we_t wr_we_n;
  word_t    wr_data;

  // Port B, read only
  addr_t    rd_addr;
  logic     rd_oe;
  word_t    rd_data;

  // Pixel packer owns port A
  modport packer (
    output wr_addr,
    output wr_we_n,
    output wr_data
  );

  // Read client owns the port B request
  modport host (
    output rd_addr,
    output rd_oe,
    input  rd_data
  );

  // Memory side sees every request and returns read data
  modport mem (
    input  wr_addr,
    input  wr_we_n,
    input  wr_data,
    input  rd_addr,
    input  rd_oe,
    output rd_data
  );

endinterface

// File: design/pixel_sram.sv
`timescale 1ns/10ps
`include "pixel_cfg.svh"

// Behavioural stand-in for the compiled 1024 x 48 dual-port cell.
// Both ports share one clock here.
module pixel_sram
  import pixel_pkg::*;
(
  input logic    ck,
  pix_mem_if.mem mem
);

  // ========================================
  // Storage array
  // ========================================

  word_t mem_q [`PIX_WORDS];

  // ========================================
  // Port A, lane writes
  // ========================================

  // Each lane has its own strobe
  // Untouched lanes keep their old content
  always_ff @(posedge ck) begin
    for (int i = 0; i < `PIX_LANES; i++) begin
      if (!mem.wr_we_n[i]) begin
        mem_q[mem.wr_addr][i*`PIX_W +: `PIX_W] <= mem.wr_data[i*`PIX_W +: `PIX_W];
      end
    end
  end

  // ========================================
  // Port B, registered read
  // ========================================

  // Array value is sampled before this edge's write lands,
  // so a same-edge read returns the old word
  always_ff @(posedge ck) begin
    if (mem.rd_oe) begin
      mem.rd_data <= mem_q[mem.rd_addr];
    end
  end

  // Output register holds between reads

endmodule

// File: design/pixel_wrapper.sv
`timescale 1ns/10ps

// Sits between the datapath and the dual-port macro.
// The macro must never see both ports on one word in the same cycle.
module pixel_wrapper
  import pixel_pkg::*;
(
  input  logic    ck,
  input  logic    rst,
  pix_mem_if.mem  up,
  pix_mem_if      dn,
  output logic    rd_valid
);

  logic  addr_hit;
  addr_t wr_addr_safe;

  // ========================================
  // Address collision steering
  // ========================================

  // Read on the word port A targets
  assign addr_hit = up.rd_oe && (up.rd_addr == up.wr_addr);

  // Port B keeps its address, port A moves to the paired word.
  // Pair differs only in bit 0
  always_comb begin
    wr_addr_safe = up.wr_addr;
    if (addr_hit) begin
      wr_addr_safe[0] = ~up.wr_addr[0];
    end
  end

  // ========================================
  // Downstream port A
  // ========================================

  assign dn.wr_addr = wr_addr_safe;
  assign dn.wr_we_n = up.wr_we_n;
  assign dn.wr_data = up.wr_data;

  // ========================================
  // Downstream port B
  // ========================================

  assign dn.rd_addr = up.rd_addr;
  assign dn.rd_oe   = up.rd_oe;

  // Read data comes back untouched
  assign up.rd_data = dn.rd_data;

  // Read data valid, aligned with the macro output register
  always_ff @(posedge ck) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= up.rd_oe;
    end
  end

endmodule

// File: design/pixel_packer.sv
`timescale 1ns/10ps
`include "pixel_cfg.svh"

// Packs a 16-bit pixel stream into 48-bit words.
// Lane 0 fills first, the word address advances after the last lane.
module pixel_packer
  import pixel_pkg::*;
(
  input  logic       ck,
  input  logic       rst,
  input  logic       frame_start,
  input  logic       pix_valid,
  input  pix_t       pix,
  pix_mem_if.packer  mem,
  output count_t     words_done
);

  localparam int     LANE_W    = $clog2(`PIX_LANES);
  localparam count_t WORDS_MAX = count_t'(`PIX_WORDS);

  // Position of the next pixel
  logic [LANE_W-1:0] lane_q;
  addr_t             addr_q;

  // Position used this cycle
  logic [LANE_W-1:0] lane_cur;
  addr_t             addr_cur;

  logic                  last_lane;
  logic                  word_full;
  logic [`PIX_LANES-1:0] lane_en;

  // ========================================
  // Current write position
  // ========================================

  // A pixel arriving with frame_start lands at word 0, lane 0
  assign lane_cur = frame_start ? '0 : lane_q;
  assign addr_cur = frame_start ? '0 : addr_q;

  assign last_lane = (lane_cur == LANE_W'(`PIX_LANES - 1));
  assign word_full = pix_valid && last_lane;

  // ========================================
  // Port A drive
  // ========================================

  // One-hot lane select, active high
  always_comb begin
    lane_en = '0;
    lane_en[lane_cur] = pix_valid;
  end

  // Pixel copied to every lane, enable picks the one that sticks
  assign mem.wr_data = {`PIX_LANES{pix}};
  assign mem.wr_we_n = ~lane_en;
  assign mem.wr_addr = addr_cur;

  // ========================================
  // Lane and address counters
  // ========================================

  always_ff @(posedge ck) begin
    if (rst) begin
      lane_q <= '0;
      addr_q <= '0;
    end else if (pix_valid) begin
      if (last_lane) begin
        lane_q <= '0;
        // Wraps 1023 to 0 on its own
        addr_q <= addr_cur + 1'b1;
      end else begin
        lane_q <= lane_cur + 1'b1;
        addr_q <= addr_cur;
      end
    end else if (frame_start) begin
      // Frame restart with no pixel
      lane_q <= '0;
      addr_q <= '0;
    end
  end

  // ========================================
  // Completed words
  // ========================================

  // Counts on the edge that writes the last lane, stops at a full buffer
  always_ff @(posedge ck) begin
    if (rst || frame_start) begin
      words_done <= '0;
    end else if (word_full && (words_done != WORDS_MAX)) begin
      words_done <= words_done + 1'b1;
    end
  end

endmodule

// File: design/pixel_buffer.sv
`timescale 1ns/10ps

// Pixel frame buffer top.
// Stream write through the packer, random word reads on port B.
module pixel_buffer
  import pixel_pkg::*;
(
  input  logic   ck,
  input  logic   rst,

  // Pixel stream
  input  logic   frame_start,
  input  logic   pix_valid,
  input  pix_t   pix,

  // Word read port
  input  logic   rd_en,
  input  addr_t  rd_addr,
  output word_t  rd_data,
  output logic   rd_valid,

  // Status
  output count_t words_done
);

  // ========================================
  // Memory buses
  // ========================================

  // Datapath side of the wrapper
  pix_mem_if up ();
  // Macro side of the wrapper
  pix_mem_if dn ();

  // Read requests enter straight from the top ports
  assign up.rd_addr = rd_addr;
  assign up.rd_oe   = rd_en;
  assign rd_data    = up.rd_data;

  // ========================================
  // Write path
  // ========================================

  pixel_packer i_packer (
    .ck          (ck),
    .rst         (rst),
    .frame_start (frame_start),
    .pix_valid   (pix_valid),
    .pix         (pix),
    .mem         (up),
    .words_done  (words_done)
  );

  // ========================================
  // Collision steering
  // ========================================

  pixel_wrapper i_wrapper (
    .ck       (ck),
    .rst      (rst),
    .up       (up),
    .dn       (dn),
    .rd_valid (rd_valid)
  );

  // ========================================
  // Dual-port memory
  // ========================================

  pixel_sram i_sram (
    .ck  (ck),
    .mem (dn)
  );

endmodule

// File: tb/tb_pixel_buffer.sv
`timescale 1ns/10ps
`include "pixel_cfg.svh"

module tb_pixel_buffer
  import pixel_pkg::*;
();

  // Roughly 1.5 times the total length of all tests
  localparam int TIMEOUT_CYCLES = 6000;

  logic   ck;
  logic   rst;
  logic   frame_start;
  logic   pix_valid;
  pix_t   pix;
  logic   rd_en;
  addr_t  rd_addr;
  word_t  rd_data;
  logic   rd_valid;
  count_t words_done;

  // ========================================
  // Reference model state
  // ========================================

  word_t                 model_mem [`PIX_WORDS];
  // Lanes written at least once since power-up
  logic [`PIX_LANES-1:0] known [`PIX_WORDS];
  int                    m_lane;
  addr_t                 m_addr;
  count_t                m_done;
  word_t                 exp_data [$];
  word_t                 exp_mask [$];
  // Last word read, the output register must hold it
  word_t                 last_exp;
  word_t                 last_mask;
  pix_t                  stream_q [$];
  int                    collisions;
  int                    cycles = 0;

  pixel_buffer i_dut (.*);

  initial begin
    ck = 1'b0;
    forever #50 ck = ~ck;
  end

  always @(posedge ck) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // ========================================
  // Checking helpers
  // ========================================

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "%s", what);
  endtask

  function automatic word_t lane_mask(input logic [`PIX_LANES-1:0] k);
    word_t m;
    m = '0;
    for (int i = 0; i < `PIX_LANES; i++) begin
      if (k[i]) m[i*`PIX_W +: `PIX_W] = '1;
    end
    return m;
  endfunction

  // Packing and collision rules for the inputs sampled at the next edge
  task automatic apply_model(input logic fs, input logic pv, input pix_t px,
                             input logic re, input addr_t ra);
    addr_t waddr;
    if (fs) begin
      m_lane = 0;
      m_addr = '0;
      m_done = '0;
    end
    // Read sees the word before this edge's write
    if (re) begin
      exp_data.push_back(model_mem[ra]);
      exp_mask.push_back(lane_mask(known[ra]));
    end
    if (pv) begin
      waddr = m_addr;
      if (re && (ra == m_addr)) begin
        waddr[0] = ~waddr[0];
        collisions++;
      end
      model_mem[waddr][m_lane*`PIX_W +: `PIX_W] = px;
      known[waddr][m_lane] = 1'b1;
      if (m_lane == `PIX_LANES - 1) begin
        m_lane = 0;
        m_addr = m_addr + 1'b1;
        if (m_done != count_t'(`PIX_WORDS)) m_done = m_done + 1'b1;
      end else begin
        m_lane++;
      end
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic run_cycle(input logic fs, input logic pv, input pix_t px,
                           input logic re, input addr_t ra);
    word_t e;
    word_t m;
    frame_start = fs;
    pix_valid   = pv;
    pix         = px;
    rd_en       = re;
    rd_addr     = ra;
    apply_model(fs, pv, px, re, ra);
    @(posedge ck);
    #1;
    if (rd_valid === 1'b1 && exp_data.size() == 0) begin
      stop_run("Read data came back although no read was issued");
    end
    check_value("rd_valid", 64'(rd_valid), 64'(exp_data.size() != 0));
    if (exp_data.size() != 0) begin
      e = exp_data.pop_front();
      m = exp_mask.pop_front();
      check_value("rd_data", 64'(rd_data & m), 64'(e & m));
      last_exp  = e;
      last_mask = m;
    end else begin
      // No read, output keeps the previous word
      check_value("rd_data", 64'(rd_data & last_mask), 64'(last_exp & last_mask));
    end
    check_value("words_done", 64'(words_done), 64'(m_done));
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic test_packing();
    pix_t  px;
    word_t exp;
    for (int n = 0; n < 300; n++) begin
      while ($urandom_range(3) == 0) begin
        run_cycle(1'b0, 1'b0, pix_t'($urandom), 1'b0, '0);
      end
      px = pix_t'($urandom);
      stream_q.push_back(px);
      run_cycle(n == 0, 1'b1, px, 1'b0, '0);
    end
    check_value("words_done", 64'(words_done), 64'd100);
    for (int w = 0; w < 100; w++) begin
      run_cycle(1'b0, 1'b0, '0, 1'b1, addr_t'(w));
      exp = {stream_q[3*w+2], stream_q[3*w+1], stream_q[3*w]};
      check_value("rd_data", 64'(rd_data), 64'(exp));
    end
  endtask

  task automatic test_partial();
    pix_t p [7];
    for (int i = 0; i < 7; i++) p[i] = pix_t'($urandom);
    // Word 0 full, word 1 lane 0 only
    for (int i = 0; i < 4; i++) run_cycle(i == 0, 1'b1, p[i], 1'b0, '0);
    run_cycle(1'b1, 1'b0, '0, 1'b0, '0);
    check_value("words_done", 64'(words_done), 64'd0);
    run_cycle(1'b0, 1'b1, p[4], 1'b0, '0);
    run_cycle(1'b0, 1'b1, p[5], 1'b0, '0);
    run_cycle(1'b0, 1'b0, '0, 1'b1, addr_t'(0));
    check_value("rd_data", 64'(rd_data), 64'({p[2], p[5], p[4]}));
    run_cycle(1'b0, 1'b0, '0, 1'b1, addr_t'(1));
    check_value("rd_data", 64'(rd_data), 64'({stream_q[5], stream_q[4], p[3]}));
    run_cycle(1'b0, 1'b1, p[6], 1'b0, '0);
    check_value("words_done", 64'(words_done), 64'd1);
  endtask

  task automatic test_collision();
    logic  pv;
    logic  re;
    addr_t ra;
    collisions = 0;
    for (int n = 0; n < 200; n++) begin
      pv = ($urandom_range(3) != 0);
      re = ($urandom_range(1) == 0);
      ra = ($urandom_range(1) == 0) ? m_addr : addr_t'($urandom_range(63));
      run_cycle(1'b0, pv, pix_t'($urandom), re, ra);
    end
    if (collisions == 0) stop_run("No read ever hit the word being written");
    // Steered pixels show up in the paired words
    for (int w = 0; w < 64; w++) run_cycle(1'b0, 1'b0, '0, 1'b1, addr_t'(w));
  endtask

  task automatic test_saturation();
    addr_t ra;
    for (int n = 0; n < 3100; n++) begin
      ra = ($urandom_range(3) == 0) ? m_addr : addr_t'($urandom);
      run_cycle(n == 0, 1'b1, pix_t'($urandom), 1'b1, ra);
    end
    check_value("words_done", 64'(words_done), 64'(`PIX_WORDS));
    // Words overwritten after the address wrapped
    for (int w = 0; w < 12; w++) run_cycle(1'b0, 1'b0, '0, 1'b1, addr_t'(w));
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin
    void'($urandom(32'hf13f));
    rst         = 1'b1;
    frame_start = 1'b0;
    pix_valid   = 1'b0;
    pix         = '0;
    // Read requested during reset, rd_valid must still clear
    rd_en       = 1'b1;
    rd_addr     = '0;
    m_lane      = 0;
    m_addr      = '0;
    m_done      = '0;
    last_exp    = '0;
    last_mask   = '0;
    collisions  = 0;
    for (int i = 0; i < `PIX_WORDS; i++) known[i] = '0;
    repeat (2) @(posedge ck);
    #1;
    rst   = 1'b0;
    rd_en = 1'b0;
    check_value("rd_valid", 64'(rd_valid), 64'd0);
    check_value("words_done", 64'(words_done), 64'd0);
    test_packing();
    test_partial();
    test_collision();
    test_saturation();
    $display("sim passed");
    $finish;
  end

endmodule

// File: pixel_buffer.f
+incdir+design
design/pixel_pkg.sv
design/pix_mem_if.sv
design/pixel_sram.sv
design/pixel_wrapper.sv
design/pixel_packer.sv
design/pixel_buffer.sv
tb/tb_pixel_buffer.sv

// File: Makefile
# Verilator build for the pixel frame buffer

VERILATOR ?= verilator
TOP       ?= tb_pixel_buffer
RTL_TOP   ?= pixel_buffer
FILELIST  ?= pixel_buffer.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?=

SOURCES := $(FILELIST) $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary --timing -j $(JOBS) --top-module $(TOP) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR) $(VFLAGS)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
